//--- Makefile
# Verilator build for the lane testbench
# make lint | make sim | make clean

VERILATOR  := verilator
TOP        := tb_spec_link
RTL_TOP    := spec_link_top
FILELIST   := tb.f
BUILD_DIR  := obj_dir
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
PASS_MSG   := *** TEST PASSED ***

SIM_BIN    := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST) | grep -v '^+') include/spec_params.svh
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

sim: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -q -F "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- tb.f
+incdir+include
src/spec_pkg.sv
src/pkt_fifo.sv
src/tof_delay.sv
src/tx_recirc.sv
src/rx_buffer.sv
src/spec_link_top.sv
verif/tb_spec_link.sv

//--- verif/tb_spec_link.sv
// Lane testbench; each table row sets packet count, write gaps, pop gaps and a pop stall
// Expected packets are queued from the host writes and none may be dropped
`timescale 1ns/1ns
`include "spec_params.svh"

module tb_spec_link;
  import spec_pkg::*;

  localparam int NUM_TESTS  = 6;
  localparam int WAIT_LIMIT = 2000;
  // Highest receive occupancy that allows a launch plus one in flight
  localparam int OCC_LIMIT  = `SPEC_RX_DEPTH - `SPEC_RX_MARGIN;
  // Packets the lane holds with pop stalled
  localparam int FULL_LOAD  = `SPEC_TX_DEPTH + OCC_LIMIT;

  // One row of the stimulus table
  typedef struct packed {
    int count;
    int max_gap;
    int max_pop_gap;
    int hold_low;
  } test_row_t;

  // Columns are count, max idle gap, max pop gap and pop held low
  localparam test_row_t TESTS [NUM_TESTS] = '{
    '{12, 15, 3,  0},
    '{20, 0,  0,  0},
    '{16, 3,  7,  0},
    '{14, 4,  1,  150},
    '{28, 1,  2,  200},
    '{24, 7,  15, 0}
  };

  logic        clk;
  logic        rst;
  packet_t     din;
  logic        pop;
  logic        full_out;
  req_t        req;
  packet_t     link;
  packet_t     rx_out;
  logic [15:0] drop_count;

  // Scoreboard with one queue per observation point
  packet_t     link_q [$];
  packet_t     exp_q [$];
  // Pre-drawn stimulus of the running test
  packet_t     pkts [$];
  int          wgap [$];
  int          pgap [$];

  logic [31:0] lfsr;
  int          errors;
  int          checks;
  logic        timeout_hit;
  logic        saw_full;
  int          cycle_cnt;
  int          last_rise;
  int          rx_occ;
  logic        link_prev;

  spec_link_top UUT (
    .clk        (clk),
    .rst        (rst),
    .din        (din),
    .full_out   (full_out),
    .req        (req),
    .link       (link),
    .pop        (pop),
    .rx_out     (rx_out),
    .drop_count (drop_count)
  );

  always #4 clk = ~clk;

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  // 32-bit Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  // One LFSR step per bit
  task automatic take_bits(input int n, output logic [31:0] v);
    int i;
    v = '0;
    for (i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  // Dest, source and data compared field by field
  task automatic compare_packet(input string where, input packet_t got, input packet_t exp);
    check_value($sformatf("%s.dest", where), 64'(got.dest), 64'(exp.dest));
    check_value($sformatf("%s.source", where), 64'(got.source), 64'(exp.source));
    check_value($sformatf("%s.data", where), 64'(got.data), 64'(exp.data));
  endtask

  task automatic report_timeout(input string what);
    errors++;
    timeout_hit = 1'b1;
    $display("Timeout: waited %0d cycles for %s", WAIT_LIMIT, what);
  endtask

  //////////////////////////////////////////////////
  // Monitor on the rising edge
  //////////////////////////////////////////////////

  always @(posedge clk) begin
    if (!rst) begin
      cycle_cnt = cycle_cnt + 1;
      if (full_out) begin
        saw_full = 1'b1;
      end
      // Fibre output carries the oldest launch first
      if (link.valid) begin
        if (link_q.size() == 0) begin
          errors++;
          $display("A packet appeared on link although none was waiting");
        end else begin
          compare_packet("link", link, link_q.pop_front());
        end
        // No launch past nearly_full and at most one in flight
        check_value("rx occupancy below bound", 64'(rx_occ < OCC_LIMIT), 64'(1));
        if (!link_prev && last_rise >= 0) begin
          check_value("link.valid spacing ok",
                      64'((cycle_cnt - last_rise) >= `SPEC_SLOT_SIZE), 64'(1));
        end
        if (!link_prev) begin
          last_rise = cycle_cnt;
        end
      end
      link_prev = link.valid;
      rx_occ    = rx_occ + int'(link.valid) - int'(pop);
      // Request must name the oldest packet not yet on link
      if (req.valid) begin
        if (link_q.size() == 0) begin
          errors++;
          $display("req.valid went high with no packet waiting");
        end else begin
          check_value("req.port", 64'(req.port), 64'(link_q[0].dest));
        end
      end
      if (din.valid) begin
        link_q.push_back(din);
        exp_q.push_back(din);
      end
    end
  end

  //////////////////////////////////////////////////
  // Host sides driven on the falling edge
  //////////////////////////////////////////////////

  task automatic write_packets(input int n);
    int i;
    int w;
    int t;
    for (i = 0; i < n && !timeout_hit; i++) begin
      for (w = 0; w < wgap[i]; w++) begin
        @(negedge clk);
      end
      // Write only while there is room
      t = 0;
      while (full_out && t < WAIT_LIMIT) begin
        @(negedge clk);
        t++;
      end
      if (full_out) begin
        report_timeout("full_out to clear");
      end else begin
        din = pkts[i];
        @(negedge clk);
        din = '0;
      end
    end
  endtask

  task automatic pop_packets(input int n, input int hold);
    int got;
    int t;
    int g;
    got = 0;
    // Stalled reader
    repeat (hold) @(negedge clk);
    while (got < n && !timeout_hit) begin
      t = 0;
      while (!rx_out.valid && t < WAIT_LIMIT) begin
        @(negedge clk);
        t++;
      end
      if (!rx_out.valid) begin
        report_timeout("a delivery on rx_out");
      end else begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("rx_out held a packet that was never written");
        end else begin
          compare_packet("rx_out", rx_out, exp_q.pop_front());
        end
        pop = 1'b1;
        got++;
        @(negedge clk);
        pop = 1'b0;
        for (g = 0; g < pgap[got-1]; g++) begin
          @(negedge clk);
        end
      end
    end
  endtask

  task automatic run_test(input int idx);
    test_row_t   row;
    int          err_start;
    int          i;
    logic [31:0] v;
    packet_t     p;
    row       = TESTS[idx];
    err_start = errors;
    saw_full  = 1'b0;
    pkts.delete();
    wgap.delete();
    pgap.delete();
    // Draw the whole test before it starts
    for (i = 0; i < row.count; i++) begin
      take_bits(PORT_W, v);
      p.dest = PORT_W'(v);
      take_bits(PORT_W, v);
      p.source = PORT_W'(v);
      take_bits(`SPEC_DATA_W, v);
      p.data  = `SPEC_DATA_W'(v);
      p.valid = 1'b1;
      pkts.push_back(p);
      take_bits(8, v);
      wgap.push_back(int'(v) % (row.max_gap + 1));
      take_bits(8, v);
      pgap.push_back(int'(v) % (row.max_pop_gap + 1));
    end
    fork
      write_packets(row.count);
      pop_packets(row.count, row.hold_low);
    join
    // Lane drained with no extra packet left behind
    check_value("rx_out.valid", 64'(rx_out.valid), 64'(0));
    check_value("req.valid", 64'(req.valid), 64'(0));
    check_value("drop_count", 64'(drop_count), 64'(0));
    // Stalled reader and more packets than the lane holds
    if (row.count > FULL_LOAD && row.hold_low >= row.count * (row.max_gap + 1)) begin
      check_value("full_out seen high", 64'(saw_full), 64'(1));
    end
    $display("test %0d: %0d packets, pop held low %0d cycles, %0d errors",
             idx, row.count, row.hold_low, errors - err_start);
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    int ti;
    int tests_run;
    clk         = 1'b0;
    rst         = 1'b1;
    din         = '0;
    pop         = 1'b0;
    lfsr        = 32'd96617;
    errors      = 0;
    checks      = 0;
    timeout_hit = 1'b0;
    saw_full    = 1'b0;
    cycle_cnt   = 0;
    last_rise   = -1;
    rx_occ      = 0;
    link_prev   = 1'b0;
    tests_run   = 0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    // Idle lane after reset
    check_value("req.valid", 64'(req.valid), 64'(0));
    check_value("link.valid", 64'(link.valid), 64'(0));
    check_value("rx_out.valid", 64'(rx_out.valid), 64'(0));
    check_value("full_out", 64'(full_out), 64'(0));
    check_value("drop_count", 64'(drop_count), 64'(0));
    $display("test reset: %0d errors", errors);
    for (ti = 0; ti < NUM_TESTS && !timeout_hit; ti++) begin
      run_test(ti);
      tests_run++;
    end
    $display("tests run: %0d of %0d, checks: %0d, errors: %0d",
             tests_run, NUM_TESTS, checks, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

//--- src/spec_link_top.sv
// One lane: transmitter, fibre, receive buffer
// req goes to an external scheduler; no grant comes back
// link is a probe of the fibre output
`timescale 1ns/1ns

module spec_link_top (
  input  logic              clk,
  input  logic              rst,
  // Host write side
  input  spec_pkg::packet_t din,
  output logic              full_out,
  // Scheduler side
  output spec_pkg::req_t    req,
  // Fibre probe
  output spec_pkg::packet_t link,
  // Host read side
  input  logic              pop,
  output spec_pkg::packet_t rx_out,
  output logic [15:0]       drop_count
);
  import spec_pkg::*;

  // Receiver levels, combinational loop-free feedback
  rx_status_t rx_status;

  //////////////////////////////////////////////////
  // Transmit end
  //////////////////////////////////////////////////

  tx_recirc u_tx (
    .clk       (clk),
    .rst       (rst),
    .din       (din),
    .rx_status (rx_status),
    .req       (req),
    .link      (link),
    .full_out  (full_out)
  );

  //////////////////////////////////////////////////
  // Receive end
  //////////////////////////////////////////////////

  rx_buffer u_rx (
    .clk        (clk),
    .rst        (rst),
    .link       (link),
    .pop        (pop),
    .rx_out     (rx_out),
    .rx_status  (rx_status),
    .drop_count (drop_count)
  );

endmodule

//--- src/rx_buffer.sv
// Receive buffer at the far end of the fibre
// Status is combinational and goes straight back to the transmitter
// drop_count wraps after 65535 drops
`timescale 1ns/1ns
`include "spec_params.svh"

module rx_buffer (
  input  logic                 clk,
  input  logic                 rst,
  input  spec_pkg::packet_t    link,
  input  logic                 pop,
  output spec_pkg::packet_t    rx_out,
  output spec_pkg::rx_status_t rx_status,
  output logic [15:0]          drop_count
);

  logic buf_full;
  logic buf_nearly_full;
  logic accept;
  logic drop;

  //////////////////////////////////////////////////
  // Arrival handling
  //////////////////////////////////////////////////

  // Packet fits unless the buffer is already full
  assign accept = link.valid && !buf_full;
  assign drop   = link.valid && buf_full;

  // Show-ahead storage, head goes to the host
  pkt_fifo #(
    .DEPTH  (`SPEC_RX_DEPTH),
    .MARGIN (`SPEC_RX_MARGIN)
  ) rx_fifo (
    .clk         (clk),
    .rst         (rst),
    .din         (link),
    .wr_en       (accept),
    .rd_en       (pop),
    .dout        (rx_out),
    .full        (buf_full),
    .nearly_full (buf_nearly_full),
    .empty       ()
  );

  // Back to the transmitter, no register
  always_comb begin
    rx_status.full        = buf_full;
    rx_status.nearly_full = buf_nearly_full;
  end

  // Overflow drops
  always_ff @(posedge clk) begin
    if (rst) begin
      drop_count <= '0;
    end else if (drop) begin
      drop_count <= drop_count + 16'd1;
    end
  end

  // Host pops only a visible head
  a_pop_valid: assert property (@(posedge clk) disable iff (rst)
    pop |-> rx_out.valid)
    else $error("rx_buffer: pop with no packet at rx_out");

endmodule

//--- src/tx_recirc.sv
// Single-FIFO speculative transmitter; launches need a free slot and receiver room
// Requests are speculative and no grant is awaited
// Host must keep din.valid low while full_out is high
`timescale 1ns/1ns
`include "spec_params.svh"

module tx_recirc (
  input  logic                 clk,
  input  logic                 rst,
  input  spec_pkg::packet_t    din,
  input  spec_pkg::rx_status_t rx_status,
  output spec_pkg::req_t       req,
  output spec_pkg::packet_t    link,
  output logic                 full_out
);
  import spec_pkg::*;

  localparam int               CNT_W    = $clog2(`SPEC_SLOT_SIZE) + 1;
  localparam logic [CNT_W-1:0] SLOT_END = CNT_W'(`SPEC_SLOT_SIZE);

  packet_t          fifo_head;
  packet_t          launch_reg;
  logic             fifo_full;
  logic             fifo_empty;
  logic             slot_ready;
  logic             rx_blocked;
  logic             launch;
  logic [CNT_W-1:0] slot_cnt;

  //////////////////////////////////////////////////
  // Input FIFO
  //////////////////////////////////////////////////

  // Every valid host word is written
  pkt_fifo #(
    .DEPTH  (`SPEC_TX_DEPTH),
    .MARGIN (0)
  ) input_fifo (
    .clk         (clk),
    .rst         (rst),
    .din         (din),
    .wr_en       (din.valid),
    .rd_en       (launch),
    .dout        (fifo_head),
    .full        (fifo_full),
    .nearly_full (),
    .empty       (fifo_empty)
  );

  assign full_out = fifo_full;

  //////////////////////////////////////////////////
  // Slot pacer and request
  //////////////////////////////////////////////////

  // Rests at SLOT_END, restarts at 1 on a request
  always_ff @(posedge clk) begin
    if (rst) begin
      slot_cnt <= SLOT_END;
    end else if (req.valid) begin
      slot_cnt <= CNT_W'(1);
    end else if (slot_cnt != SLOT_END) begin
      slot_cnt <= slot_cnt + 1'b1;
    end
  end

  assign slot_ready = (slot_cnt == SLOT_END);

  // Request names the head's destination
  always_comb begin
    req.valid = !fifo_empty && slot_ready;
    req.port  = fifo_head.dest;
  end

  // Either level holds the head back; the slot is still spent
  assign rx_blocked = rx_status.full || rx_status.nearly_full;
  assign launch     = req.valid && !rx_blocked;

  //////////////////////////////////////////////////
  // Launch register and fibre
  //////////////////////////////////////////////////

  // Head is popped into the register on launch
  always_ff @(posedge clk) begin
    if (rst) begin
      launch_reg.valid <= 1'b0;
    end else if (launch) begin
      launch_reg <= fifo_head;
    end else begin
      launch_reg.valid <= 1'b0;
    end
  end

  // TOF plus one cycles in flight
  tof_delay #(
    .STAGES (`SPEC_TOF + 1)
  ) send_delay (
    .clk  (clk),
    .rst  (rst),
    .din  (launch_reg),
    .dout (link)
  );

  // Arrivals keep the slot spacing after the fibre
  for (genvar g = 1; g < `SPEC_SLOT_SIZE; g++) begin : g_slot_gap
    a_slot_gap: assert property (@(posedge clk) disable iff (rst)
      $rose(link.valid) |-> !$past(link.valid, g))
      else $error("tx_recirc: two launches within one slot");
  end

endmodule

//--- src/tof_delay.sv
// Fibre model: fixed latency of STAGES cycles, no back-pressure
// STAGES must be at least 1
`timescale 1ns/1ns

module tof_delay #(
  parameter int STAGES = 4
) (
  input  logic              clk,
  input  logic              rst,
  input  spec_pkg::packet_t din,
  output spec_pkg::packet_t dout
);
  import spec_pkg::*;

  // One packet per stage along the fibre
  packet_t stage [STAGES];

  //////////////////////////////////////////////////
  // Shift chain
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      // Empty fibre, payload left as is
      for (int i = 0; i < STAGES; i++) begin
        stage[i].valid <= 1'b0;
      end
    end else begin
      stage[0] <= din;
      // Advance one stage per cycle
      for (int i = 1; i < STAGES; i++) begin
        stage[i] <= stage[i-1];
      end
    end
  end

  // Far end of the fibre
  assign dout = stage[STAGES-1];

endmodule

//--- src/pkt_fifo.sv
// Show-ahead packet FIFO; dout.valid is low whenever the FIFO is empty
// Writes while full and reads while empty are ignored
`timescale 1ns/1ns

module pkt_fifo #(
  parameter int DEPTH  = 8,
  parameter int MARGIN = 0
) (
  input  logic              clk,
  input  logic              rst,
  input  spec_pkg::packet_t din,
  input  logic              wr_en,
  input  logic              rd_en,
  output spec_pkg::packet_t dout,
  output logic              full,
  output logic              nearly_full,
  output logic              empty
);
  import spec_pkg::*;

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  packet_t          mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  fifo_state_e      state;
  logic             do_wr;
  logic             do_rd;

  // Wrap a pointer at DEPTH, also for non power of two depths
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
    if (p == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return p + 1'b1;
  endfunction

  // Effective strobes, illegal ones are dropped
  assign do_wr = wr_en && (state != FIFO_FULL);
  assign do_rd = rd_en && (state != FIFO_EMPTY);

  // Classify occupancy
  always_comb begin
    if (count == '0) begin
      state = FIFO_EMPTY;
    end else if (count == CNT_W'(DEPTH)) begin
      state = FIFO_FULL;
    end else if ((CNT_W'(DEPTH) - count) <= CNT_W'(MARGIN)) begin
      state = FIFO_NEARLY_FULL;
    end else begin
      state = FIFO_PARTIAL;
    end
  end

  // Storage
  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= din;
    end
  end

  // Pointers and occupancy
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= ptr_next(wr_ptr);
      end
      if (do_rd) begin
        rd_ptr <= ptr_next(rd_ptr);
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Head is visible without a read, valid only while occupied
  always_comb begin
    dout       = mem[rd_ptr];
    dout.valid = (state != FIFO_EMPTY);
  end

  // Flags, nearly_full includes full
  assign full        = (state == FIFO_FULL);
  assign nearly_full = (state == FIFO_NEARLY_FULL) || (state == FIFO_FULL);
  assign empty       = (state == FIFO_EMPTY);

  // Caller must respect the flags
  a_no_wr_full: assert property (@(posedge clk) disable iff (rst)
    wr_en |-> (state != FIFO_FULL))
    else $error("pkt_fifo: write while full, packet dropped");
  a_no_rd_empty: assert property (@(posedge clk) disable iff (rst)
    rd_en |-> (state != FIFO_EMPTY))
    else $error("pkt_fifo: read while empty");

endmodule

//--- src/spec_pkg.sv
// Shared types of the lane; field widths follow the params header
// packet_t is valid, dest, source, data from MSB down
`include "spec_params.svh"

package spec_pkg;

  // Width of a port index
  localparam int PORT_W = $clog2(`SPEC_PORTS);

  // One packet on the host side, in the FIFOs and on the fibre
  typedef struct packed {
    logic                    valid;
    logic [PORT_W-1:0]       dest;
    logic [PORT_W-1:0]       source;
    logic [`SPEC_DATA_W-1:0] data;
  } packet_t;

  // Speculative request to the external scheduler
  typedef struct packed {
    logic              valid;
    logic [PORT_W-1:0] port;
  } req_t;

  // Receiver levels fed back to the transmitter
  typedef struct packed {
    logic full;
    logic nearly_full;
  } rx_status_t;

  // Occupancy classes of a packet FIFO
  typedef enum logic [1:0] {
    FIFO_EMPTY,
    FIFO_PARTIAL,
    FIFO_NEARLY_FULL,
    FIFO_FULL
  } fifo_state_e;

endpackage

//--- include/spec_params.svh
// Build-time constants for one transmit lane of the slotted network
// SPEC_RX_MARGIN has to cover every packet that can be in flight
`ifndef SPEC_PARAMS_SVH
`define SPEC_PARAMS_SVH

//////////////////////////////////////////////////
// Network geometry
//////////////////////////////////////////////////

// Port count, sets dest and source widths
`define SPEC_PORTS      4
// Payload bits per packet
`define SPEC_DATA_W     32

//////////////////////////////////////////////////
// Buffering and timing
//////////////////////////////////////////////////

`define SPEC_TX_DEPTH   8
`define SPEC_RX_DEPTH   16
// Cycles per slot, at most one launch per slot
`define SPEC_SLOT_SIZE  8
// Fibre time of flight in cycles
`define SPEC_TOF        3
// Free entries left when the receiver says nearly full
`define SPEC_RX_MARGIN  (`SPEC_TOF + 2)

`endif
